//--- files.f
+incdir+verilog
verilog/y86_isa_pkg.sv
verilog/y86_pipe_pkg.sv
verilog/y86_fetch.sv
verilog/y86_regfile.sv
verilog/y86_decode.sv
verilog/y86_execute.sv
verilog/y86_cpu.sv
bench/y86_cpu_sva.sv
bench/y86_cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f files.f --top-module y86_cpu_tb -o y86_cpu_sim

status=0
./obj_dir/y86_cpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "FAIL"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "FAIL: simulator exited with status $status"
	exit 1
fi
echo "PASS"

//--- bench/y86_cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "y86_defs.svh"

module y86_cpu_tb;

	localparam int CLK_HALF = 4;
	localparam int RAND_SEED = 9097;
	localparam int ROM_BYTES = 256;
	localparam int PROG1_INSTS = 60;
	localparam int PROG2_INSTS = 21;
	localparam int CMOV_SLOT = 30;
	localparam int TIMEOUT_CYCLES = 4 * (PROG1_INSTS + PROG2_INSTS) + 50;

	logic			clk;
	logic			reset;
	y86_isa_pkg::inst_win_t	rom_data;
	y86_isa_pkg::pc_t	rom_addr;
	y86_pipe_pkg::wb_t	wb;
	y86_isa_pkg::stat_e	stat;
	logic			halted;

	logic [7:0]		rom [ROM_BYTES];
	y86_isa_pkg::word_t	m_regs [`Y86_NREG];
	y86_pipe_pkg::wb_t	exp_q [$];
	y86_isa_pkg::stat_e	exp_stat;
	int			error_count = 0;
	int			check_count = 0;
	int			cmov_taken = 0;
	int			cmov_skipped = 0;
	int			cycle_count = 0;

	y86_cpu DUT (
		.clk(clk),		.reset_i(reset),
		.rom_data_i(rom_data),	.rom_addr_o(rom_addr),
		.wb_o(wb),		.stat_o(stat),
		.halted_o(halted)
	);

	bind y86_cpu y86_cpu_sva sva0 (
		.clk(clk),		.reset_i(reset_i),
		.pc_i(rom_addr_o),	.wb_i(wb_o),
		.halted_i(halted_o)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// The ROM answers in the same cycle. Bytes past its end read as zero.
	always_comb begin
		for (int k = 0; k < `Y86_INST_BYTES; k++) begin
			if (int'(rom_addr) + k < ROM_BYTES)
				rom_data[k*8 +: 8] = rom[8'(int'(rom_addr) + k)];
			else
				rom_data[k*8 +: 8] = 8'h00;
		end
	end

	function automatic logic [7:0] rom_byte(input int addr);
		if (addr < ROM_BYTES)
			return rom[8'(addr)];
		return 8'h00;
	endfunction

	// Edge values turn up now and then so that the zero and overflow flags get exercised.
	function automatic y86_isa_pkg::word_t pick_imm();
		case ($urandom % 8)
			0: return 64'h0;
			1: return 64'h7fff_ffff_ffff_ffff;
			2: return 64'h8000_0000_0000_0000;
			3: return 64'hffff_ffff_ffff_ffff;
			default: return {$urandom, $urandom};
		endcase
	endfunction

	function automatic bit cond_holds(input logic [3:0] fn, input bit zf, input bit sf,
			input bit of);
		case (fn)
			4'h0: return 1'b1;
			4'h1: return (sf ^ of) | zf;
			4'h2: return sf ^ of;
			4'h3: return zf;
			4'h4: return !zf;
			4'h5: return !(sf ^ of);
			4'h6: return !(sf ^ of) && !zf;
			default: return 1'b0;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Program and model.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic build_program(input int n_body, input bit bad_end);
		int pc;
		int kind;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] fn;
		y86_isa_pkg::word_t imm;
		pc = 0;
		for (int a = 0; a < ROM_BYTES; a++)
			rom[8'(a)] = 8'h00;
		for (int i = 0; i < n_body; i++) begin
			ra = 4'($urandom % 15);
			rb = 4'($urandom % 15);
			kind = int'($urandom % 8);
			if (i < 3)
				kind = 1;
			else if (i == CMOV_SLOT)
				kind = 4;
			else if (i == CMOV_SLOT + 1)
				kind = 7;
			// An irmovq has to leave room for the rest of the program.
			if ((kind == 1 || kind == 2)
					&& pc + 10 + 2 * (n_body - i - 1) + 1 > ROM_BYTES)
				kind = 4;
			case (kind)
				0: begin
					rom[8'(pc)] = 8'h10;
					pc += 1;
				end
				1, 2: begin
					imm = pick_imm();
					rom[8'(pc)] = 8'h30;
					rom[8'(pc + 1)] = {4'hf, rb};
					for (int k = 0; k < 8; k++)
						rom[8'(pc + 2 + k)] = imm[k*8 +: 8];
					pc += 10;
				end
				3, 7: begin
					fn = (kind == 3) ? 4'h0 : 4'(1 + $urandom % 6);
					rom[8'(pc)] = {4'h2, fn};
					rom[8'(pc + 1)] = {ra, rb};
					pc += 2;
				end
				default: begin
					rom[8'(pc)] = {4'h6, 4'($urandom % 4)};
					rom[8'(pc + 1)] = {ra, rb};
					pc += 2;
				end
			endcase
		end
		if (bad_end) begin
			// Codes 4, 5 and 7 to 15 are outside the subset.
			kind = int'($urandom % 11);
			fn = (kind < 2) ? 4'(4 + kind) : 4'(5 + kind);
			rom[8'(pc)] = {fn, 4'($urandom % 16)};
		end else begin
			rom[8'(pc)] = 8'h00;
		end
	endtask

	task automatic expect_write(input y86_isa_pkg::reg_id_t dst,
			input y86_isa_pkg::word_t value);
		y86_pipe_pkg::wb_t w;
		w.valid = 1'b1;
		w.dst = dst;
		w.value = value;
		m_regs[dst] = value;
		exp_q.push_back(w);
	endtask

	task automatic run_model();
		int pc;
		logic [3:0] icode;
		logic [3:0] fn;
		logic [3:0] ra;
		logic [3:0] rb;
		y86_isa_pkg::word_t va;
		y86_isa_pkg::word_t vb;
		y86_isa_pkg::word_t vc;
		logic [64:0] wide;
		bit zf;
		bit sf;
		bit of;
		bit take;
		exp_q.delete();
		for (int r = 0; r < `Y86_NREG; r++)
			m_regs[r] = '0;
		{zf, sf, of} = 3'b100;
		pc = 0;
		exp_stat = y86_isa_pkg::AOK;
		while (exp_stat == y86_isa_pkg::AOK && pc < ROM_BYTES) begin
			{icode, fn} = rom_byte(pc);
			{ra, rb} = rom_byte(pc + 1);
			for (int k = 0; k < 8; k++)
				vc[k*8 +: 8] = rom_byte(pc + 2 + k);
			va = (ra < 4'hf) ? m_regs[ra] : '0;
			vb = (rb < 4'hf) ? m_regs[rb] : '0;
			case (icode)
				4'h0: exp_stat = y86_isa_pkg::HLT;
				4'h1: pc += 1;
				4'h2: begin
					if (fn > 4'h6) begin
						exp_stat = y86_isa_pkg::INS;
					end else begin
						take = cond_holds(fn, zf, sf, of);
						if (take)
							expect_write(rb, va);
						if (fn != 4'h0 && take)
							cmov_taken++;
						else if (fn != 4'h0)
							cmov_skipped++;
						pc += 2;
					end
				end
				4'h3: begin
					expect_write(rb, vc);
					pc += 10;
				end
				4'h6: begin
					// One extra sign bit shows a signed overflow.
					case (fn)
						4'h0: wide = {vb[63], vb} + {va[63], va};
						4'h1: wide = {vb[63], vb} - {va[63], va};
						4'h2: wide = {vb[63] & va[63], vb & va};
						4'h3: wide = {vb[63] ^ va[63], vb ^ va};
						default: exp_stat = y86_isa_pkg::INS;
					endcase
					if (exp_stat == y86_isa_pkg::AOK) begin
						zf = (wide[63:0] == '0);
						sf = wide[63];
						of = wide[64] ^ wide[63];
						expect_write(rb, wide[63:0]);
						pc += 2;
					end
				end
				default: exp_stat = y86_isa_pkg::INS;
			endcase
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Checks and run control.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic check_wb(input y86_pipe_pkg::wb_t got,
			input y86_pipe_pkg::wb_t exp);
		check_count++;
		if (got.dst !== exp.dst || got.value !== exp.value) begin
			error_count++;
			$display("CHECK FAILED at %0t: wb_o got dst %0d value %h, %s %0d value %h",
				$time, got.dst, got.value, "expected dst", exp.dst, exp.value);
		end
	endtask

	task automatic check_stat(input y86_isa_pkg::stat_e got, input y86_isa_pkg::stat_e exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED at %0t: stat_o got %s, expected %s",
				$time, got.name(), exp.name());
		end
	endtask

	task automatic take_write();
		if (exp_q.size() == 0) begin
			error_count++;
			$display("ERROR: register %0d written at %0t when no write was expected",
				wb.dst, $time);
		end else begin
			check_wb(wb, exp_q.pop_front());
		end
	endtask

	// The ROM is loaded while the core is held in reset.
	task automatic load_program(input int n_body, input bit bad_end);
		reset <= 1'b1;
		build_program(n_body, bad_end);
		run_model();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic run_dut();
		bit stop;
		stop = 1'b0;
		while (!stop) begin
			@(negedge clk);
			if (wb.valid)
				take_write();
			stop = halted;
		end
		repeat (4) begin
			@(negedge clk);
			if (wb.valid)
				take_write();
		end
		if (!halted) begin
			error_count++;
			$display("ERROR: halted_o fell again after the core stopped");
		end
		check_stat(stat, exp_stat);
		if (exp_q.size() != 0) begin
			error_count++;
			$display("ERROR: %0d expected register writes never appeared", exp_q.size());
		end
	endtask

	task automatic finish_run();
		$display("Summary: %0d checks, %0d errors, %0d cmov taken, %0d cmov not taken",
			check_count, error_count, cmov_taken, cmov_skipped);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		reset = 1'b1;
		void'($urandom(RAND_SEED));
		load_program(PROG1_INSTS - 1, 1'b0);
		run_dut();
		@(posedge clk);
		load_program(PROG2_INSTS - 1, 1'b1);
		run_dut();
		finish_run();
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		error_count++;
		$display("ERROR: the core did not stop within %0d cycles", TIMEOUT_CYCLES);
		finish_run();
	end

endmodule

`default_nettype wire

//--- bench/y86_cpu_sva.sv
`timescale 1ns/100ps
`default_nettype none

module y86_cpu_sva (
	input	wire	clk,
	input	wire	reset_i,
	input	wire	y86_isa_pkg::pc_t	pc_i,
	input	wire	y86_pipe_pkg::wb_t	wb_i,
	input	wire	halted_i
);

	// A stopped core keeps its PC on the stopping instruction.
	pc_frozen: assert property (@(posedge clk) disable iff (reset_i)
		halted_i |=> $stable(pc_i))
		else $error("PC moved while the core was halted");

	no_write_halted: assert property (@(posedge clk) disable iff (reset_i)
		halted_i |-> !wb_i.valid)
		else $error("register write seen while halted");

	// Only real registers are written.
	dst_named: assert property (@(posedge clk) disable iff (reset_i)
		wb_i.valid |-> wb_i.dst != y86_isa_pkg::REG_NONE)
		else $error("register write without a destination");

endmodule

`default_nettype wire

//--- verilog/y86_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module y86_cpu (
	input	wire	clk,
	input	wire	reset_i,
	input	wire	y86_isa_pkg::inst_win_t	rom_data_i,
	output	y86_isa_pkg::pc_t		rom_addr_o,
	output	y86_pipe_pkg::wb_t		wb_o,
	output	y86_isa_pkg::stat_e		stat_o,
	output	logic				halted_o
);

	y86_pipe_pkg::fd_t	fd;
	y86_pipe_pkg::de_t	de;
	y86_pipe_pkg::wb_t	ex_fwd;
	y86_pipe_pkg::wb_t	wb;
	y86_isa_pkg::reg_id_t	src_a;
	y86_isa_pkg::reg_id_t	src_b;
	y86_isa_pkg::word_t	val_a;
	y86_isa_pkg::word_t	val_b;

	y86_fetch fetch0 (
		.clk(clk),		.reset_i(reset_i),
		.rom_data_i(rom_data_i),
		.pc_o(rom_addr_o),	.fd_o(fd)
	);

	y86_regfile regfile0 (
		.clk(clk),		.reset_i(reset_i),
		.src_a_i(src_a),	.src_b_i(src_b),
		.val_a_o(val_a),	.val_b_o(val_b),
		.wb_i(wb)
	);

	y86_decode decode0 (
		.clk(clk),		.reset_i(reset_i),
		.fd_i(fd),
		.src_a_o(src_a),	.src_b_o(src_b),
		.val_a_i(val_a),	.val_b_i(val_b),
		.ex_fwd_i(ex_fwd),	.wb_i(wb),
		.de_o(de)
	);

	y86_execute execute0 (
		.clk(clk),		.reset_i(reset_i),
		.de_i(de),
		.ex_fwd_o(ex_fwd),	.wb_o(wb),
		.stat_o(stat_o),	.halted_o(halted_o)
	);

	assign wb_o = wb;

endmodule

`default_nettype wire

//--- verilog/y86_execute.sv
`timescale 1ns/100ps
`default_nettype none
`include "y86_defs.svh"

module y86_execute (
	input	wire	clk,
	input	wire	reset_i,
	input	wire	y86_pipe_pkg::de_t	de_i,
	output	y86_pipe_pkg::wb_t		ex_fwd_o,
	output	y86_pipe_pkg::wb_t		wb_o,
	output	y86_isa_pkg::stat_e		stat_o,
	output	logic				halted_o
);

	localparam int MSB = `Y86_WORD_W - 1;

	y86_isa_pkg::word_t	alu_r;
	logic			alu_v;
	y86_isa_pkg::word_t	val_e;
	y86_isa_pkg::cc_t	cc_q;
	logic			zf;
	logic			sf;
	logic			lt;
	logic			cond_ok;
	logic			is_ok;
	y86_pipe_pkg::wb_t	wb_q;
	y86_isa_pkg::stat_e	stat_q;
	logic			halted_q;

	// ~~~~~~~~~~~~~~~~~~~~
	// ALU computing valB op valA.
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		alu_v = 1'b0;
		case (y86_isa_pkg::alufn_e'(de_i.ifun))
			y86_isa_pkg::ADD: begin
				alu_r = de_i.val_b + de_i.val_a;
				alu_v = (de_i.val_a[MSB] == de_i.val_b[MSB])
					&& (alu_r[MSB] != de_i.val_b[MSB]);
			end
			y86_isa_pkg::SUB: begin
				alu_r = de_i.val_b - de_i.val_a;
				alu_v = (de_i.val_a[MSB] != de_i.val_b[MSB])
					&& (alu_r[MSB] != de_i.val_b[MSB]);
			end
			y86_isa_pkg::AND: alu_r = de_i.val_b & de_i.val_a;
			default: alu_r = de_i.val_b ^ de_i.val_a;
		endcase
		case (de_i.icode)
			y86_isa_pkg::IRMOVQ: val_e = de_i.val_c;
			y86_isa_pkg::RRMOVQ: val_e = de_i.val_a;
			default: val_e = alu_r;
		endcase
	end

	// Move condition against the flags left by the last opq.
	always_comb begin
		zf = cc_q[y86_isa_pkg::CC_ZF];
		sf = cc_q[y86_isa_pkg::CC_SF];
		lt = sf ^ cc_q[y86_isa_pkg::CC_OF];
		case (y86_isa_pkg::cond_e'(de_i.ifun))
			y86_isa_pkg::ALWAYS: cond_ok = 1'b1;
			y86_isa_pkg::LE: cond_ok = lt | zf;
			y86_isa_pkg::L: cond_ok = lt;
			y86_isa_pkg::E: cond_ok = zf;
			y86_isa_pkg::NE: cond_ok = !zf;
			y86_isa_pkg::GE: cond_ok = !lt;
			y86_isa_pkg::G: cond_ok = !lt && !zf;
			default: cond_ok = 1'b0;
		endcase
	end

	assign is_ok = de_i.valid && (de_i.stat == y86_isa_pkg::AOK);

	// Early bypass; a move that is not taken writes nothing.
	always_comb begin
		ex_fwd_o.valid = is_ok && (de_i.dst_e != y86_isa_pkg::REG_NONE)
			&& (de_i.icode != y86_isa_pkg::RRMOVQ || cond_ok);
		ex_fwd_o.dst = de_i.dst_e;
		ex_fwd_o.value = val_e;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Flags, writeback and status.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset_i) begin
			cc_q <= y86_isa_pkg::CC_RESET;
			wb_q.valid <= 1'b0;
			stat_q <= y86_isa_pkg::AOK;
			halted_q <= 1'b0;
		end else begin
			wb_q <= ex_fwd_o;
			if (is_ok && de_i.icode == y86_isa_pkg::OPQ)
				cc_q <= {alu_r == '0, alu_r[MSB], alu_v};
			if (de_i.valid && de_i.stat != y86_isa_pkg::AOK && !halted_q) begin
				stat_q <= de_i.stat;
				halted_q <= 1'b1;
			end
		end
	end

	assign wb_o = wb_q;
	assign stat_o = stat_q;
	assign halted_o = halted_q;

endmodule

`default_nettype wire

//--- verilog/y86_decode.sv
`timescale 1ns/100ps
`default_nettype none

module y86_decode (
	input	wire	clk,
	input	wire	reset_i,
	input	wire	y86_pipe_pkg::fd_t	fd_i,
	output	y86_isa_pkg::reg_id_t	src_a_o,
	output	y86_isa_pkg::reg_id_t	src_b_o,
	input	wire	y86_isa_pkg::word_t	val_a_i,
	input	wire	y86_isa_pkg::word_t	val_b_i,
	input	wire	y86_pipe_pkg::wb_t	ex_fwd_i,
	input	wire	y86_pipe_pkg::wb_t	wb_i,
	output	y86_pipe_pkg::de_t		de_o
);

	y86_isa_pkg::reg_id_t	src_a;
	y86_isa_pkg::reg_id_t	src_b;
	y86_isa_pkg::reg_id_t	dst_e;
	y86_pipe_pkg::de_t	de_d;
	y86_pipe_pkg::de_t	de_q;

	// Execute holds the youngest producer and beats writeback, and writeback beats the file.
	function automatic y86_isa_pkg::word_t pick_operand(
		input y86_isa_pkg::reg_id_t src,
		input y86_isa_pkg::word_t rf_val,
		input y86_pipe_pkg::wb_t ex_fwd,
		input y86_pipe_pkg::wb_t wb
	);
		if (ex_fwd.valid && ex_fwd.dst == src)
			return ex_fwd.value;
		if (wb.valid && wb.dst == src)
			return wb.value;
		return rf_val;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Register selection.
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		src_a = y86_isa_pkg::REG_NONE;
		src_b = y86_isa_pkg::REG_NONE;
		dst_e = y86_isa_pkg::REG_NONE;
		case (fd_i.icode)
			y86_isa_pkg::RRMOVQ: begin
				src_a = fd_i.ra;
				dst_e = fd_i.rb;
			end
			y86_isa_pkg::IRMOVQ: dst_e = fd_i.rb;
			y86_isa_pkg::OPQ: begin
				src_a = fd_i.ra;
				src_b = fd_i.rb;
				dst_e = fd_i.rb;
			end
			default: ;
		endcase
	end

	assign src_a_o = src_a;
	assign src_b_o = src_b;

	always_comb begin
		de_d.valid = fd_i.valid;
		de_d.icode = fd_i.icode;
		de_d.ifun = fd_i.ifun;
		de_d.val_a = pick_operand(src_a, val_a_i, ex_fwd_i, wb_i);
		de_d.val_b = pick_operand(src_b, val_b_i, ex_fwd_i, wb_i);
		de_d.val_c = fd_i.val_c;
		de_d.dst_e = dst_e;
		de_d.stat = fd_i.stat;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			de_q.valid <= 1'b0;
		else
			de_q <= de_d;
	end

	assign de_o = de_q;

endmodule

`default_nettype wire

//--- verilog/y86_regfile.sv
`timescale 1ns/100ps
`default_nettype none
`include "y86_defs.svh"

module y86_regfile (
	input	wire	clk,
	input	wire	reset_i,
	input	wire	y86_isa_pkg::reg_id_t	src_a_i,
	input	wire	y86_isa_pkg::reg_id_t	src_b_i,
	output	y86_isa_pkg::word_t		val_a_o,
	output	y86_isa_pkg::word_t		val_b_o,
	input	wire	y86_pipe_pkg::wb_t	wb_i
);

	y86_isa_pkg::word_t	regs [`Y86_NREG];

	// Reads are combinational; the none id reads as zero.
	assign val_a_o = (src_a_i == y86_isa_pkg::REG_NONE) ? '0 : regs[src_a_i];
	assign val_b_o = (src_b_i == y86_isa_pkg::REG_NONE) ? '0 : regs[src_b_i];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `Y86_NREG; i++)
				regs[i] <= '0;
		end else if (wb_i.valid && wb_i.dst != y86_isa_pkg::REG_NONE) begin
			regs[wb_i.dst] <= wb_i.value;
		end
	end

endmodule

`default_nettype wire

//--- verilog/y86_fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "y86_defs.svh"

module y86_fetch (
	input	wire	clk,
	input	wire	reset_i,
	input	wire	y86_isa_pkg::inst_win_t	rom_data_i,
	output	y86_isa_pkg::pc_t		pc_o,
	output	y86_pipe_pkg::fd_t		fd_o
);

	y86_isa_pkg::pc_t		pc_q;
	y86_isa_pkg::pc_t		ilen;
	y86_pipe_pkg::fetch_state_e	state_q;
	y86_pipe_pkg::fd_t		fd_d;
	y86_pipe_pkg::fd_t		fd_q;

	// ~~~~~~~~~~~~~~~~~~~~
	// Field split and length.
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		fd_d.valid = (state_q == y86_pipe_pkg::RUN);
		fd_d.icode = y86_isa_pkg::icode_e'(rom_data_i[7:4]);
		fd_d.ifun = rom_data_i[3:0];
		fd_d.ra = rom_data_i[15:12];
		fd_d.rb = rom_data_i[11:8];
		// The immediate follows the register byte, low byte first.
		fd_d.val_c = rom_data_i[`Y86_INST_BYTES*8-1:16];
		fd_d.stat = y86_isa_pkg::AOK;
		ilen = y86_isa_pkg::pc_t'(1);
		case (fd_d.icode)
			y86_isa_pkg::HALT: fd_d.stat = y86_isa_pkg::HLT;
			y86_isa_pkg::NOP: ilen = y86_isa_pkg::pc_t'(1);
			y86_isa_pkg::RRMOVQ: begin
				ilen = y86_isa_pkg::pc_t'(2);
				if (fd_d.ifun > y86_isa_pkg::G)
					fd_d.stat = y86_isa_pkg::INS;
			end
			y86_isa_pkg::IRMOVQ: ilen = y86_isa_pkg::pc_t'(`Y86_INST_BYTES);
			y86_isa_pkg::OPQ: begin
				ilen = y86_isa_pkg::pc_t'(2);
				if (fd_d.ifun > y86_isa_pkg::XOR)
					fd_d.stat = y86_isa_pkg::INS;
			end
			default: fd_d.stat = y86_isa_pkg::INS;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// PC and stop control.
	// ~~~~~~~~~~~~~~~~~~~~

	// A halt or a bad code is passed on once, then the PC freezes on it.
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= '0;
			state_q <= y86_pipe_pkg::RUN;
			fd_q.valid <= 1'b0;
		end else begin
			fd_q <= fd_d;
			if (state_q == y86_pipe_pkg::RUN) begin
				if (fd_d.stat == y86_isa_pkg::AOK)
					pc_q <= pc_q + ilen;
				else
					state_q <= y86_pipe_pkg::STOPPED;
			end
		end
	end

	assign pc_o = pc_q;
	assign fd_o = fd_q;

endmodule

`default_nettype wire

//--- verilog/y86_pipe_pkg.sv
`default_nettype none

package y86_pipe_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Stage registers.
	// ~~~~~~~~~~~~~~~~~~~~

	// Raw fields of one instruction as fetch hands them to decode.
	typedef struct packed {
		logic                 valid;
		y86_isa_pkg::icode_e  icode;
		y86_isa_pkg::ifun_t   ifun;
		y86_isa_pkg::reg_id_t ra;
		y86_isa_pkg::reg_id_t rb;
		y86_isa_pkg::word_t   val_c;
		y86_isa_pkg::stat_e   stat;
	} fd_t;

	// Decode hands execute its operands after bypass.
	typedef struct packed {
		logic                 valid;
		y86_isa_pkg::icode_e  icode;
		y86_isa_pkg::ifun_t   ifun;
		y86_isa_pkg::word_t   val_a;
		y86_isa_pkg::word_t   val_b;
		y86_isa_pkg::word_t   val_c;
		y86_isa_pkg::reg_id_t dst_e;
		y86_isa_pkg::stat_e   stat;
	} de_t;

	// One register write that also serves as a bypass source.
	typedef struct packed {
		logic                 valid;
		y86_isa_pkg::reg_id_t dst;
		y86_isa_pkg::word_t   value;
	} wb_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Fetch control.
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic {
		RUN     = 1'b0,
		STOPPED = 1'b1
	} fetch_state_e;

endpackage

`default_nettype wire

//--- verilog/y86_isa_pkg.sv
`default_nettype none
`include "y86_defs.svh"

package y86_isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Machine words and fields.
	// ~~~~~~~~~~~~~~~~~~~~
	typedef logic [`Y86_WORD_W-1:0] word_t;
	typedef logic [`Y86_PC_W-1:0] pc_t;
	typedef logic [`Y86_INST_BYTES*8-1:0] inst_win_t;
	typedef logic [3:0] reg_id_t;
	typedef logic [3:0] ifun_t;

	// Register id 15 names no register.
	localparam reg_id_t REG_NONE = 4'hf;

	// ~~~~~~~~~~~~~~~~~~~~
	// Instruction codes.
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		HALT   = 4'h0,
		NOP    = 4'h1,
		RRMOVQ = 4'h2,
		IRMOVQ = 4'h3,
		OPQ    = 4'h6
	} icode_e;

	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		XOR = 4'h3
	} alufn_e;

	// Function code of rrmovq and the conditional moves.
	typedef enum logic [3:0] {
		ALWAYS = 4'h0,
		LE     = 4'h1,
		L      = 4'h2,
		E      = 4'h3,
		NE     = 4'h4,
		GE     = 4'h5,
		G      = 4'h6
	} cond_e;

	typedef enum logic [1:0] {
		AOK = 2'd0,
		HLT = 2'd1,
		INS = 2'd2
	} stat_e;

	// Condition codes are kept as {zero, sign, overflow}.
	typedef logic [2:0] cc_t;
	localparam int CC_ZF = 2;
	localparam int CC_SF = 1;
	localparam int CC_OF = 0;
	localparam cc_t CC_RESET = 3'b100;

endpackage

`default_nettype wire

//--- verilog/y86_defs.svh
`ifndef Y86_DEFS_SVH
`define Y86_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Machine sizes.
// ~~~~~~~~~~~~~~~~~~~~

// Width of a machine word and of every program register.
`define Y86_WORD_W 64

// Width of an instruction address into the ROM.
`define Y86_PC_W 16

// Bytes in the fetch window, enough for the longest instruction.
`define Y86_INST_BYTES 10

// Program registers %rax through %r14.
`define Y86_NREG 15

`endif
